// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = fpuTb
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = RESULT: FAIL
PASS_MSG = RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: bench/fpuTb.sv
`timescale 1ns/1ns

module fpuTb;
  import fpuPkg::*;

  // random sign-injection ops and random compares
  localparam int sgnCount = 40;
  localparam int cmpCount = 80;
  // reset, load and readback, sgnj, specials, compares, invalid, write-through
  localparam int testCycles = 2 + 64 + 3 * sgnCount + 14 + 4 + cmpCount + 12 + 9;
  localparam int timeoutLimit = testCycles + 20;

  typedef struct packed {
    logic             inval;
    logic             wr;
    logic [flagW-1:0] flags;
    logic [dataW-1:0] res;
  } refOut_s;

  typedef struct packed {
    logic [31:0]      due;
    logic [flagW-1:0] flags;
    logic [dataW-1:0] res;
  } expect_s;

  logic             clk;
  logic             arstN;
  logic [31:0]      instrD;
  logic [dataW-1:0] srcA;
  logic             fInvalInstrD;
  logic [dataW-1:0] fpuResult;
  logic [flagW-1:0] setFflags;

  // shadow copy of the fp register file updated at issue
  logic [dataW-1:0] shadow [32];
  expect_s          sbQ [$];
  expect_s          cur;
  logic             expInval;
  int               cycleCnt = 0;
  int               seed;
  int               checkCnt = 0;
  int               resultErrs = 0;
  int               flagErrs = 0;
  int               decodeErrs = 0;

  fpuTop u_dut (
    .clk(clk), .arstN(arstN), .instrD(instrD), .srcA(srcA),
    .fInvalInstrD(fInvalInstrD), .fpuResult(fpuResult), .setFflags(setFflags)
  );

  // ******************************
  // clock and cycle count
  // ******************************
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCnt <= cycleCnt + 1;
  end

  initial begin : watchdog
    wait (cycleCnt >= timeoutLimit);
    $display("timeout: run did not finish within %0d cycles", timeoutLimit);
    $display("RESULT: FAIL");
    $finish;
  end

  // ******************************
  // helpers
  // ******************************
  function automatic logic [31:0] randWord();
    randWord = $random(seed);
  endfunction

  function automatic logic [31:0] encodeOpFp(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
    encodeOpFp = {f7, rs2, rs1, f3, rd, opFp};
  endfunction

  // signed zeros, NaNs and plain numbers in both formats
  // singles carry a full box
  function automatic logic [63:0] specialValue(input int k);
    case (k)
      0:       specialValue = 64'h0000_0000_0000_0000;
      1:       specialValue = 64'h8000_0000_0000_0000;
      2:       specialValue = 64'h7ff8_0000_0000_0000;
      3:       specialValue = 64'h7ff0_0000_0000_0001;
      4:       specialValue = 64'h3ff0_0000_0000_0000;
      5:       specialValue = 64'hc000_0000_0000_0000;
      6:       specialValue = 64'hffff_ffff_0000_0000;
      7:       specialValue = 64'hffff_ffff_8000_0000;
      8:       specialValue = 64'hffff_ffff_7fc0_0000;
      9:       specialValue = 64'hffff_ffff_7f80_0001;
      10:      specialValue = 64'hffff_ffff_3f80_0000;
      default: specialValue = 64'hffff_ffff_c000_0000;
    endcase
  endfunction

  // expected decode, result, flags and register write of one instruction
  function automatic refOut_s refFpu(input logic [31:0] ins, input logic [63:0] a,
                                     input logic [63:0] b, input logic [63:0] src);
    refOut_s     r;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic        dbl;
    logic        sA;
    logic        sB;
    logic        sNew;
    logic        nanA;
    logic        nanB;
    logic        snanA;
    logic        snanB;
    logic [62:0] magA;
    logic [62:0] magB;
    logic        eq;
    logic        lt;
    logic        isSgn;
    logic        isCmp;
    logic        isMove;
    r = '0;
    f7 = ins[31:25];
    f3 = ins[14:12];
    dbl = f7[0];
    isSgn = (f7 == funct7SgnjS || f7 == funct7SgnjD) &&
            (f3 == funct3Sgnj || f3 == funct3Sgnjn || f3 == funct3Sgnjx);
    isCmp = (f7 == funct7CmpS || f7 == funct7CmpD) &&
            (f3 == funct3Feq || f3 == funct3Flt || f3 == funct3Fle);
    isMove = (f7 == funct7MvDX) && (ins[24:20] == 5'd0) && (f3 == 3'b000);
    if (dbl) begin
      sA = a[63];
      sB = b[63];
      magA = a[62:0];
      magB = b[62:0];
      nanA = (&a[62:52]) && (|a[51:0]);
      nanB = (&b[62:52]) && (|b[51:0]);
      snanA = nanA && !a[51];
      snanB = nanB && !b[51];
    end else begin
      // single lives in the low half and the box is ignored on input
      sA = a[31];
      sB = b[31];
      magA = {32'd0, a[30:0]};
      magB = {32'd0, b[30:0]};
      nanA = (&a[30:23]) && (|a[22:0]);
      nanB = (&b[30:23]) && (|b[22:0]);
      snanA = nanA && !a[22];
      snanB = nanB && !b[22];
    end
    eq = (magA == '0 && magB == '0) || (sA == sB && magA == magB);
    if (magA == '0 && magB == '0) begin
      lt = 1'b0;
    end else if (sA != sB) begin
      lt = sA;
    end else begin
      lt = sA ? (magA > magB) : (magA < magB);
    end
    if (ins[6:0] != opFp) begin
      // bubble writes nothing and flags nothing
      r = '0;
    end else if (isMove) begin
      r.wr = 1'b1;
      r.res = src;
    end else if (isSgn) begin
      case (f3)
        funct3Sgnj:  sNew = sB;
        funct3Sgnjn: sNew = ~sB;
        default:     sNew = sA ^ sB;
      endcase
      r.wr = 1'b1;
      r.res = dbl ? {sNew, a[62:0]} : {32'hffff_ffff, sNew, a[30:0]};
    end else if (isCmp) begin
      case (f3)
        funct3Feq: begin
          r.res[0] = !(nanA || nanB) && eq;
          r.flags[flagNv] = snanA || snanB;
        end
        funct3Flt: begin
          r.res[0] = !(nanA || nanB) && lt;
          r.flags[flagNv] = nanA || nanB;
        end
        default: begin
          r.res[0] = !(nanA || nanB) && (lt || eq);
          r.flags[flagNv] = nanA || nanB;
        end
      endcase
    end else begin
      r.inval = 1'b1;
    end
    return r;
  endfunction

  // drive one instruction and queue what must come out three cycles later
  task automatic issue(input logic [31:0] ins, input logic [63:0] src);
    refOut_s r;
    expect_s e;
    @(posedge clk);
    #10;
    r = refFpu(ins, shadow[ins[19:15]], shadow[ins[24:20]], src);
    instrD = ins;
    srcA = src;
    expInval = r.inval;
    if (r.wr) begin
      shadow[ins[11:7]] = r.res;
    end
    e.due = cycleCnt + 3;
    e.flags = r.flags;
    e.res = r.res;
    sbQ.push_back(e);
  endtask

  task automatic bubble();
    issue(32'h0, '0);
  endtask

  // next instruction may then read what this one writes
  task automatic issueSpaced(input logic [31:0] ins, input logic [63:0] src);
    issue(ins, src);
    bubble();
    bubble();
  endtask

  // ******************************
  // checker
  // ******************************
  always @(negedge clk) begin
    if (arstN) begin
      checkCnt++;
      assert (fInvalInstrD == expInval) else begin
        decodeErrs++;
        $display("ERROR at %0t ns: fInvalInstrD %b, expected %b for instrD 0x%h",
                 $time, fInvalInstrD, expInval, instrD);
      end
      if (sbQ.size() > 0 && sbQ[0].due == cycleCnt) begin
        cur = sbQ.pop_front();
        assert (fpuResult == cur.res) else begin
          resultErrs++;
          $display("ERROR at %0t ns: fpuResult 0x%h, expected 0x%h",
                   $time, fpuResult, cur.res);
        end
        assert (setFflags == cur.flags) else begin
          flagErrs++;
          $display("ERROR at %0t ns: setFflags %b, expected %b",
                   $time, setFflags, cur.flags);
        end
      end
    end
  end

  // ******************************
  // stimulus
  // ******************************
  initial begin : stimulus
    logic [31:0] r32;
    logic [6:0]  f7;
    logic [2:0]  f3;
    instrD = '0;
    srcA = '0;
    arstN = 1'b0;
    expInval = 1'b0;
    seed = 70381;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    repeat (2) @(posedge clk);
    #10 arstN = 1'b1;

    // fill every register and read each back unchanged through fsgnj.d
    for (int i = 0; i < 32; i++) begin
      issue(encodeOpFp(funct7MvDX, 5'd0, 5'd0, 3'b000, 5'(i)), {randWord(), randWord()});
    end
    for (int i = 0; i < 32; i++) begin
      issue(encodeOpFp(funct7SgnjD, 5'(i), 5'(i), funct3Sgnj, 5'(i)), '0);
    end

    // random sign injection in both formats
    for (int n = 0; n < sgnCount; n++) begin
      r32 = randWord();
      f7 = r32[0] ? funct7SgnjD : funct7SgnjS;
      case (r32[2:1])
        2'd0:    f3 = funct3Sgnj;
        2'd1:    f3 = funct3Sgnjn;
        default: f3 = funct3Sgnjx;
      endcase
      issueSpaced(encodeOpFp(f7, r32[17:13], r32[12:8], f3, r32[7:3]), '0);
    end

    // specials go into f20..f31 while f16..f19 keep random data
    for (int k = 0; k < 12; k++) begin
      issue(encodeOpFp(funct7MvDX, 5'd0, 5'd0, 3'b000, 5'(20 + k)), specialValue(k));
    end
    bubble();
    bubble();
    // +0 == -0, qNaN in flt, sNaN in feq, single +0 <= -0
    issue(encodeOpFp(funct7CmpD, 5'd21, 5'd20, funct3Feq, 5'd1), '0);
    issue(encodeOpFp(funct7CmpD, 5'd24, 5'd22, funct3Flt, 5'd1), '0);
    issue(encodeOpFp(funct7CmpD, 5'd23, 5'd23, funct3Feq, 5'd1), '0);
    issue(encodeOpFp(funct7CmpS, 5'd27, 5'd26, funct3Fle, 5'd1), '0);
    // compares write nothing so they can go back to back
    for (int n = 0; n < cmpCount; n++) begin
      r32 = randWord();
      f7 = r32[0] ? funct7CmpD : funct7CmpS;
      case (r32[2:1])
        2'd0:    f3 = funct3Feq;
        2'd1:    f3 = funct3Flt;
        default: f3 = funct3Fle;
      endcase
      issue(encodeOpFp(f7, {1'b1, r32[15:12]}, {1'b1, r32[11:8]}, f3, r32[20:16]), '0);
    end

    // fadd.d and a bad sgnj funct3 are not supported here
    issueSpaced(encodeOpFp(7'b0000001, 5'd2, 5'd3, 3'b000, 5'd5), '0);
    issueSpaced(encodeOpFp(funct7SgnjS, 5'd2, 5'd3, 3'b011, 5'd6), '0);
    // f5 and f6 must still hold their old values
    issueSpaced(encodeOpFp(funct7SgnjD, 5'd5, 5'd5, funct3Sgnj, 5'd5), '0);
    issueSpaced(encodeOpFp(funct7SgnjD, 5'd6, 5'd6, funct3Sgnj, 5'd6), '0);

    // read lands on the write edge
    issueSpaced(encodeOpFp(funct7MvDX, 5'd0, 5'd0, 3'b000, 5'd7), {randWord(), randWord()});
    issueSpaced(encodeOpFp(funct7SgnjD, 5'd7, 5'd7, funct3Sgnj, 5'd8), '0);
    issueSpaced(encodeOpFp(funct7SgnjS, 5'd8, 5'd8, funct3Sgnjn, 5'd9), '0);

    while (sbQ.size() != 0) begin
      @(posedge clk);
    end
    @(posedge clk);
    $display("checks: %0d, result errors: %0d, flag errors: %0d, decode errors: %0d",
             checkCnt, resultErrs, flagErrs, decodeErrs);
    if (resultErrs + flagErrs + decodeErrs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: bench/fpuTop_properties.sv
`timescale 1ns/1ns

module fpuTopProperties (
  input logic                      clk,
  input logic                      arstN,
  input logic [31:0]               instrD,
  input logic                      fInvalInstrD,
  input logic [fpuPkg::dataW-1:0]  fpuResult,
  input logic [fpuPkg::flagW-1:0]  setFflags
);
  import fpuPkg::*;

  // ******************************
  // output rules
  // ******************************

  // NV is the msb, everything below it stays clear
  onlyNvFlag: assert property (@(posedge clk) disable iff (!arstN)
    setFflags[flagNv-1:0] == '0)
    else $error("setFflags raised a flag other than NV");

  // pipeline still holds bubbles for three edges after reset release
  quietAfterReset: assert property (@(posedge clk) disable iff (!arstN)
    $rose(arstN) |-> (fpuResult == '0 && setFflags == '0)
      ##1 (fpuResult == '0 && setFflags == '0)
      ##1 (fpuResult == '0 && setFflags == '0))
    else $error("fpuResult or setFflags not zero right after reset");

  // only OP-FP words can be illegal fp instructions
  invalOnlyOpFp: assert property (@(posedge clk) disable iff (!arstN)
    (instrD[6:0] != opFp) |-> !fInvalInstrD)
    else $error("fInvalInstrD raised for a non OP-FP opcode");

endmodule

bind fpuTop fpuTopProperties u_props (
  .clk(clk), .arstN(arstN), .instrD(instrD), .fInvalInstrD(fInvalInstrD),
  .fpuResult(fpuResult), .setFflags(setFflags)
);

// File: hw/fpCompare.sv
`timescale 1ns/1ns

module fpCompare (
  input  logic             clk,
  input  logic             arstN,
  input  fpuPkg::fpWord_u  rs1E,
  input  fpuPkg::fpWord_u  rs2E,
  input  logic             fmtE,
  input  logic [2:0]       opE,
  output logic             cmpResultM,
  output logic             cmpInvalidM
);
  import fpuPkg::*;

  logic       aNanE, bNanE, aSnanE, bSnanE;
  logic       aZeroE, bZeroE, signAE, signBE;
  logic       magLtE, magEqE;
  logic       aNanM, bNanM, aSnanM, bSnanM;
  logic       aZeroM, bZeroM, signAM, signBM;
  logic       magLtM, magEqM;
  logic [2:0] opM;
  logic       anyNan, anySnan, bothZero;
  logic       eqM, ltM;

  // ******************************
  // execute: classify and order
  // ******************************
  always_comb begin
    if (fmtE) begin
      aNanE  = (&rs1E.d.exp) && (|rs1E.d.frac);
      bNanE  = (&rs2E.d.exp) && (|rs2E.d.frac);
      // quiet bit is the fraction msb
      aSnanE = aNanE && !rs1E.d.frac[51];
      bSnanE = bNanE && !rs2E.d.frac[51];
      aZeroE = (rs1E.d.exp == '0) && (rs1E.d.frac == '0);
      bZeroE = (rs2E.d.exp == '0) && (rs2E.d.frac == '0);
      signAE = rs1E.d.sign;
      signBE = rs2E.d.sign;
      // exponent:fraction orders like an unsigned magnitude
      magLtE = {rs1E.d.exp, rs1E.d.frac} < {rs2E.d.exp, rs2E.d.frac};
      magEqE = {rs1E.d.exp, rs1E.d.frac} == {rs2E.d.exp, rs2E.d.frac};
    end else begin
      // single view, box bits ignored
      aNanE  = (&rs1E.s.exp) && (|rs1E.s.frac);
      bNanE  = (&rs2E.s.exp) && (|rs2E.s.frac);
      aSnanE = aNanE && !rs1E.s.frac[22];
      bSnanE = bNanE && !rs2E.s.frac[22];
      aZeroE = (rs1E.s.exp == '0) && (rs1E.s.frac == '0);
      bZeroE = (rs2E.s.exp == '0) && (rs2E.s.frac == '0);
      signAE = rs1E.s.sign;
      signBE = rs2E.s.sign;
      magLtE = {rs1E.s.exp, rs1E.s.frac} < {rs2E.s.exp, rs2E.s.frac};
      magEqE = {rs1E.s.exp, rs1E.s.frac} == {rs2E.s.exp, rs2E.s.frac};
    end
  end

  // E/M register
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {aNanM, bNanM, aSnanM, bSnanM} <= '0;
      {aZeroM, bZeroM, signAM, signBM} <= '0;
      {magLtM, magEqM} <= '0;
      opM <= '0;
    end else begin
      {aNanM, bNanM, aSnanM, bSnanM} <= {aNanE, bNanE, aSnanE, bSnanE};
      {aZeroM, bZeroM, signAM, signBM} <= {aZeroE, bZeroE, signAE, signBE};
      {magLtM, magEqM} <= {magLtE, magEqE};
      opM <= opE;
    end
  end

  // ******************************
  // memory: resolve
  // ******************************
  always_comb begin
    anyNan   = aNanM | bNanM;
    anySnan  = aSnanM | bSnanM;
    // +0 and -0 compare equal
    bothZero = aZeroM & bZeroM;
    eqM = bothZero | ((signAM == signBM) && magEqM);
    if (bothZero) begin
      ltM = 1'b0;
    end else if (signAM != signBM) begin
      // negative one is smaller
      ltM = signAM;
    end else if (!signAM) begin
      ltM = magLtM;
    end else begin
      // both negative, larger magnitude is smaller
      ltM = ~magLtM & ~magEqM;
    end
    cmpResultM  = 1'b0;
    cmpInvalidM = 1'b0;
    case (opM)
      // feq is quiet, only snan raises NV
      funct3Feq: begin
        cmpResultM  = ~anyNan & eqM;
        cmpInvalidM = anySnan;
      end
      // flt/fle are signaling on any nan
      funct3Flt: begin
        cmpResultM  = ~anyNan & ltM;
        cmpInvalidM = anyNan;
      end
      funct3Fle: begin
        cmpResultM  = ~anyNan & (ltM | eqM);
        cmpInvalidM = anyNan;
      end
      default: begin
        cmpResultM  = 1'b0;
        cmpInvalidM = 1'b0;
      end
    endcase
  end

endmodule

// File: hw/fpRegFile.sv
`timescale 1ns/1ns

module fpRegFile (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic [fpuPkg::regAddrW-1:0]   rs1D,
  input  logic [fpuPkg::regAddrW-1:0]   rs2D,
  input  logic [fpuPkg::dataW-1:0]      srcA,
  input  logic                          writeEn,
  input  logic [fpuPkg::regAddrW-1:0]   writeAddr,
  input  logic [fpuPkg::dataW-1:0]      writeData,
  output fpuPkg::fpWord_u               rs1E,
  output fpuPkg::fpWord_u               rs2E,
  output logic [fpuPkg::dataW-1:0]      srcAE
);
  import fpuPkg::*;

  // 32 fp registers, f0 is an ordinary register
  fpWord_u regs [2**regAddrW];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 2**regAddrW; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn) begin
      regs[writeAddr] <= writeData;
    end
  end

  // operand read registered into execute
  // same-cycle write wins so a reader three behind sees fresh data
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rs1E  <= '0;
      rs2E  <= '0;
      srcAE <= '0;
    end else begin
      rs1E  <= (writeEn && (writeAddr == rs1D)) ? writeData : regs[rs1D];
      rs2E  <= (writeEn && (writeAddr == rs2D)) ? writeData : regs[rs2D];
      // integer operand for fmv rides along with the fp reads
      srcAE <= srcA;
    end
  end

endmodule

// File: hw/fpSignMove.sv
`timescale 1ns/1ns

module fpSignMove (
  input  logic                      clk,
  input  logic                      arstN,
  input  fpuPkg::fpWord_u           rs1E,
  input  fpuPkg::fpWord_u           rs2E,
  input  logic [fpuPkg::dataW-1:0]  srcAE,
  input  logic                      fmtE,
  input  logic [2:0]                opE,
  input  logic                      moveE,
  output logic [fpuPkg::dataW-1:0]  sgnResultM
);
  import fpuPkg::*;

  logic    signA;
  logic    signB;
  logic    signNew;
  fpWord_u resultE;

  always_comb begin
    // sign bit sits at 63 for double, 31 for single
    signA = fmtE ? rs1E.d.sign : rs1E.s.sign;
    signB = fmtE ? rs2E.d.sign : rs2E.s.sign;
    case (opE)
      funct3Sgnj:  signNew = signB;
      funct3Sgnjn: signNew = ~signB;
      funct3Sgnjx: signNew = signA ^ signB;
      default:     signNew = signA;
    endcase
    // magnitude always comes from rs1
    resultE = rs1E;
    if (moveE) begin
      // fmv.d.x, raw integer bits
      resultE = srcAE;
    end else if (fmtE) begin
      resultE.d.sign = signNew;
    end else begin
      // single results get nan-boxed
      resultE.s.box  = '1;
      resultE.s.sign = signNew;
    end
  end

  // E/M register
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      sgnResultM <= '0;
    end else begin
      sgnResultM <= resultE;
    end
  end

endmodule

// File: hw/fpWriteback.sv
`timescale 1ns/1ns

module fpWriteback (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic [1:0]                resultSelM,
  input  logic [fpuPkg::dataW-1:0]  sgnResultM,
  input  logic                      cmpResultM,
  input  logic                      cmpInvalidM,
  output logic [fpuPkg::dataW-1:0]  fpuResult,
  output logic [fpuPkg::flagW-1:0]  setFflags
);
  import fpuPkg::*;

  logic [dataW-1:0] resultM;
  logic [flagW-1:0] flagsM;

  // result and flag mux in memory
  always_comb begin
    resultM = '0;
    flagsM  = '0;
    case (resultSelM)
      // sign injection and move share the sgn unit output, no flags
      resSgn, resMove: begin
        resultM = sgnResultM;
      end
      // compare: 0/1 zero-extended, NV only
      resCmp: begin
        resultM = {{(dataW-1){1'b0}}, cmpResultM};
        flagsM[flagNv] = cmpInvalidM;
      end
      // bubble
      default: begin
        resultM = '0;
        flagsM  = '0;
      end
    endcase
  end

  // M/W register
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      fpuResult <= '0;
      setFflags <= '0;
    end else begin
      fpuResult <= resultM;
      setFflags <= flagsM;
    end
  end

endmodule

// File: hw/fpuCtrl.sv
`timescale 1ns/1ns

module fpuCtrl (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic [31:0]                   instrD,
  output logic                          fInvalInstrD,
  output logic [fpuPkg::regAddrW-1:0]   rs1D,
  output logic [fpuPkg::regAddrW-1:0]   rs2D,
  output logic                          fmtE,
  output logic [2:0]                    opE,
  output logic                          sgnEnE,
  output logic                          cmpEnE,
  output logic                          moveE,
  output logic [1:0]                    resultSelM,
  output logic                          regWriteM,
  output logic [fpuPkg::regAddrW-1:0]   rdM,
  output logic                          regWriteW,
  output logic [fpuPkg::regAddrW-1:0]   rdW
);
  import fpuPkg::*;

  logic [6:0]          opcodeD;
  logic [6:0]          funct7D;
  logic [2:0]          funct3D;
  logic [regAddrW-1:0] rdD;
  logic                isOpFpD;
  logic                sgnOkD;
  logic                cmpOkD;
  logic                moveOkD;
  logic                sgnEnD;
  logic                cmpEnD;
  logic                moveD;
  logic [regAddrW-1:0] rdE;
  logic [1:0]          resultSelE;
  logic                regWriteE;

  // ******************************
  // decode
  // ******************************

  // R-type fields
  assign opcodeD = instrD[6:0];
  assign rdD     = instrD[11:7];
  assign funct3D = instrD[14:12];
  assign rs1D    = instrD[19:15];
  assign rs2D    = instrD[24:20];
  assign funct7D = instrD[31:25];
  assign isOpFpD = (opcodeD == opFp);

  always_comb begin
    sgnOkD = ((funct7D == funct7SgnjS) || (funct7D == funct7SgnjD)) &&
             ((funct3D == funct3Sgnj) || (funct3D == funct3Sgnjn) ||
              (funct3D == funct3Sgnjx));
    cmpOkD = ((funct7D == funct7CmpS) || (funct7D == funct7CmpD)) &&
             ((funct3D == funct3Feq) || (funct3D == funct3Flt) ||
              (funct3D == funct3Fle));
    // fmv.d.x only with rs2 and funct3 both zero
    moveOkD = (funct7D == funct7MvDX) && (rs2D == '0) && (funct3D == 3'b000);
    // unsupported OP-FP words flag here and go down the pipe as bubbles
    fInvalInstrD = isOpFpD & ~(sgnOkD | cmpOkD | moveOkD);
    sgnEnD = isOpFpD & sgnOkD;
    cmpEnD = isOpFpD & cmpOkD;
    moveD  = isOpFpD & moveOkD;
  end

  // ******************************
  // D/E register
  // ******************************
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      fmtE   <= 1'b0;
      opE    <= '0;
      sgnEnE <= 1'b0;
      cmpEnE <= 1'b0;
      moveE  <= 1'b0;
      rdE    <= '0;
    end else begin
      // fmt is the low bit of funct7
      fmtE   <= funct7D[0];
      opE    <= funct3D;
      sgnEnE <= sgnEnD;
      cmpEnE <= cmpEnD;
      moveE  <= moveD;
      rdE    <= rdD;
    end
  end

  // compare writes the integer side, so no fp register write
  always_comb begin
    if (cmpEnE) begin
      resultSelE = resCmp;
    end else if (sgnEnE) begin
      resultSelE = resSgn;
    end else if (moveE) begin
      resultSelE = resMove;
    end else begin
      resultSelE = resNone;
    end
    regWriteE = sgnEnE | moveE;
  end

  // ******************************
  // E/M and M/W registers
  // ******************************
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      resultSelM <= resNone;
      regWriteM  <= 1'b0;
      rdM        <= '0;
      regWriteW  <= 1'b0;
      rdW        <= '0;
    end else begin
      resultSelM <= resultSelE;
      regWriteM  <= regWriteE;
      rdM        <= rdE;
      regWriteW  <= regWriteM;
      rdW        <= rdM;
    end
  end

endmodule

// File: hw/fpuPkg.sv
package fpuPkg;

  // ******************************
  // widths
  // ******************************

  // register word, always 64 bits here
  localparam int dataW = 64;
  // index into the 32-entry fp register file
  localparam int regAddrW = 5;
  // fflags are NV DZ OF UF NX, msb first
  localparam int flagW = 5;
  localparam int flagNv = 4;

  // ******************************
  // instruction encodings
  // ******************************

  // OP-FP major opcode
  localparam logic [6:0] opFp = 7'b1010011;

  // funct7, lsb is the fmt bit (1 = double)
  localparam logic [6:0] funct7SgnjS = 7'b0010000;
  localparam logic [6:0] funct7SgnjD = 7'b0010001;
  localparam logic [6:0] funct7CmpS = 7'b1010000;
  localparam logic [6:0] funct7CmpD = 7'b1010001;
  // FMV.D.X, needs rs2 = 0 and funct3 = 0
  localparam logic [6:0] funct7MvDX = 7'b1111001;

  // sign injection flavours
  localparam logic [2:0] funct3Sgnj = 3'b000;
  localparam logic [2:0] funct3Sgnjn = 3'b001;
  localparam logic [2:0] funct3Sgnjx = 3'b010;
  // compare flavours
  localparam logic [2:0] funct3Feq = 3'b010;
  localparam logic [2:0] funct3Flt = 3'b001;
  localparam logic [2:0] funct3Fle = 3'b000;

  // writeback result select
  localparam logic [1:0] resNone = 2'd0;
  localparam logic [1:0] resSgn = 2'd1;
  localparam logic [1:0] resCmp = 2'd2;
  localparam logic [1:0] resMove = 2'd3;

  // one register word, read as a double or as a boxed single
  typedef union packed {
    struct packed {
      logic        sign;
      logic [10:0] exp;
      logic [51:0] frac;
    } d;
    struct packed {
      logic [31:0] box;
      logic        sign;
      logic [7:0]  exp;
      logic [22:0] frac;
    } s;
  } fpWord_u;

endpackage

// File: hw/fpuTop.sv
`timescale 1ns/1ns

module fpuTop (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic [31:0]               instrD,
  input  logic [fpuPkg::dataW-1:0]  srcA,
  output logic                      fInvalInstrD,
  output logic [fpuPkg::dataW-1:0]  fpuResult,
  output logic [fpuPkg::flagW-1:0]  setFflags
);
  import fpuPkg::*;

  // decode stage
  logic [regAddrW-1:0] rs1D, rs2D;
  // execute stage
  fpWord_u             rs1E, rs2E;
  logic [dataW-1:0]    srcAE;
  logic                fmtE;
  logic [2:0]          opE;
  logic                moveE;
  // memory stage
  logic [1:0]          resultSelM;
  logic [dataW-1:0]    sgnResultM;
  logic                cmpResultM;
  logic                cmpInvalidM;
  // writeback stage
  logic                regWriteW;
  logic [regAddrW-1:0] rdW;

  // ******************************
  // control
  // ******************************
  // enables and memory-stage write controls only matter inside the control pipe
  fpuCtrl u_ctrl (
    .clk(clk), .arstN(arstN), .instrD(instrD), .fInvalInstrD(fInvalInstrD),
    .rs1D(rs1D), .rs2D(rs2D), .fmtE(fmtE), .opE(opE),
    .sgnEnE(), .cmpEnE(), .moveE(moveE),
    .resultSelM(resultSelM), .regWriteM(), .rdM(),
    .regWriteW(regWriteW), .rdW(rdW)
  );

  // writeback result goes straight back into the register file
  fpRegFile u_regFile (
    .clk(clk), .arstN(arstN), .rs1D(rs1D), .rs2D(rs2D), .srcA(srcA),
    .writeEn(regWriteW), .writeAddr(rdW), .writeData(fpuResult),
    .rs1E(rs1E), .rs2E(rs2E), .srcAE(srcAE)
  );

  fpSignMove u_signMove (
    .clk(clk), .arstN(arstN), .rs1E(rs1E), .rs2E(rs2E), .srcAE(srcAE),
    .fmtE(fmtE), .opE(opE), .moveE(moveE), .sgnResultM(sgnResultM)
  );

  fpCompare u_compare (
    .clk(clk), .arstN(arstN), .rs1E(rs1E), .rs2E(rs2E), .fmtE(fmtE),
    .opE(opE), .cmpResultM(cmpResultM), .cmpInvalidM(cmpInvalidM)
  );

  fpWriteback u_writeback (
    .clk(clk), .arstN(arstN), .resultSelM(resultSelM), .sgnResultM(sgnResultM),
    .cmpResultM(cmpResultM), .cmpInvalidM(cmpInvalidM),
    .fpuResult(fpuResult), .setFflags(setFflags)
  );

endmodule

// File: src.f
hw/fpuPkg.sv
hw/fpuCtrl.sv
hw/fpRegFile.sv
hw/fpSignMove.sv
hw/fpCompare.sv
hw/fpWriteback.sv
hw/fpuTop.sv
bench/fpuTop_properties.sv
bench/fpuTb.sv
